/* hdl/mips_decode_pkg.sv */
`default_nettype none

package mips_decode_pkg;

	localparam int XLEN      = 32;
	localparam int NUM_REGS  = 32;
	localparam int REG_IDX_W = 5;
	localparam int OPCODE_W  = 6;
	localparam int FUNC_W    = 6;
	localparam int SHAMT_W   = 5;
	localparam int IMM_W     = 16;
	localparam int TARGET_W  = 26;

	// Primary opcodes
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
	localparam logic [OPCODE_W-1:0] OP_MUL   = 6'b011100; // SPECIAL2, R layout
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'b001000;
	localparam logic [OPCODE_W-1:0] OP_ADDIU = 6'b001001;
	localparam logic [OPCODE_W-1:0] OP_SLTI  = 6'b001010;
	localparam logic [OPCODE_W-1:0] OP_SLTIU = 6'b001011;
	localparam logic [OPCODE_W-1:0] OP_ORI   = 6'b001101;
	localparam logic [OPCODE_W-1:0] OP_XORI  = 6'b001110;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'b100011;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'b101011;
	localparam logic [OPCODE_W-1:0] OP_LB    = 6'b100000;
	localparam logic [OPCODE_W-1:0] OP_LBU   = 6'b100100;
	localparam logic [OPCODE_W-1:0] OP_SB    = 6'b101000;
	localparam logic [OPCODE_W-1:0] OP_LUI   = 6'b001111;
	localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'b000100;
	localparam logic [OPCODE_W-1:0] OP_BNE   = 6'b000101;
	localparam logic [OPCODE_W-1:0] OP_BGTZ  = 6'b000111;
	localparam logic [OPCODE_W-1:0] OP_J     = 6'b000010;
	localparam logic [OPCODE_W-1:0] OP_JAL   = 6'b000011;

	// Function codes under OP_RTYPE
	localparam logic [FUNC_W-1:0] FN_ADD   = 6'b100000;
	localparam logic [FUNC_W-1:0] FN_ADDU  = 6'b100001;
	localparam logic [FUNC_W-1:0] FN_SUB   = 6'b100010;
	localparam logic [FUNC_W-1:0] FN_SUBU  = 6'b100011;
	localparam logic [FUNC_W-1:0] FN_MULT  = 6'b011000;
	localparam logic [FUNC_W-1:0] FN_MULTU = 6'b011001;
	localparam logic [FUNC_W-1:0] FN_DIV   = 6'b011010;
	localparam logic [FUNC_W-1:0] FN_DIVU  = 6'b011011;
	localparam logic [FUNC_W-1:0] FN_MFHI  = 6'b010000;
	localparam logic [FUNC_W-1:0] FN_MFLO  = 6'b010010;
	localparam logic [FUNC_W-1:0] FN_SLT   = 6'b101010;
	localparam logic [FUNC_W-1:0] FN_SLTU  = 6'b101011;
	localparam logic [FUNC_W-1:0] FN_SLL   = 6'b000000;
	localparam logic [FUNC_W-1:0] FN_SLLV  = 6'b000100;
	localparam logic [FUNC_W-1:0] FN_SRL   = 6'b000010;
	localparam logic [FUNC_W-1:0] FN_SRLV  = 6'b000110;
	localparam logic [FUNC_W-1:0] FN_SRA   = 6'b000011;
	localparam logic [FUNC_W-1:0] FN_SRAV  = 6'b000111;
	localparam logic [FUNC_W-1:0] FN_AND   = 6'b100100;
	localparam logic [FUNC_W-1:0] FN_OR    = 6'b100101;
	localparam logic [FUNC_W-1:0] FN_XOR   = 6'b100110;
	localparam logic [FUNC_W-1:0] FN_NOR   = 6'b100111;
	localparam logic [FUNC_W-1:0] FN_JR    = 6'b001000;
	localparam logic [FUNC_W-1:0] FN_JALR  = 6'b001001;
	localparam logic [FUNC_W-1:0] FN_MUL   = 6'b000010; // Only under OP_MUL, shares SRL code

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [OPCODE_W-1:0]  opcode;
			logic [REG_IDX_W-1:0] rs;
			logic [REG_IDX_W-1:0] rt;
			logic [REG_IDX_W-1:0] rd;
			logic [SHAMT_W-1:0]   sa;
			logic [FUNC_W-1:0]    func;
		} r;
		struct packed {
			logic [OPCODE_W-1:0]  opcode;
			logic [REG_IDX_W-1:0] rs;
			logic [REG_IDX_W-1:0] rt;
			logic [IMM_W-1:0]     imm;
		} i;
		struct packed {
			logic [OPCODE_W-1:0] opcode;
			logic [TARGET_W-1:0] target;
		} j;
	} insn_t;

endpackage

`default_nettype wire

/* hdl/insn_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_classifier import mips_decode_pkg::*; (
	input  insn_t                insn,
	output logic [OPCODE_W-1:0]  opcode,
	output logic [REG_IDX_W-1:0] rs,
	output logic [REG_IDX_W-1:0] rt,
	output logic [REG_IDX_W-1:0] rd,
	output logic [SHAMT_W-1:0]   sa,
	output logic [FUNC_W-1:0]    func,
	output logic [OPCODE_W-1:0]  alu_op,
	output logic [XLEN-1:0]      imm_sx,
	output logic [TARGET_W-1:0]  jump_target,
	output logic                 illegal
);

	logic r_known; // Function code recognized in R layout

	always_comb begin
		opcode      = '0;
		rs          = '0;
		rt          = '0;
		rd          = '0;
		sa          = '0;
		func        = '0;
		alu_op      = '0;
		imm_sx      = '0;
		jump_target = '0;
		illegal     = 1'b0;
		r_known     = 1'b1;

		case (insn.r.opcode)
			OP_RTYPE, OP_MUL: begin
				if (insn.r.opcode == OP_MUL && insn.r.func == FN_MUL) begin
					opcode = OP_MUL; // MUL rd, rs, rt
					rs     = insn.r.rs;
					rt     = insn.r.rt;
					rd     = insn.r.rd;
					func   = insn.r.func;
					alu_op = insn.r.func;
				end else begin
					case (insn.r.func)
						FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
						FN_SLT, FN_SLTU, FN_SLLV, FN_SRLV, FN_SRAV,
						FN_AND, FN_OR, FN_XOR, FN_NOR, FN_JALR: begin
							rs = insn.r.rs;
							rt = insn.r.rt;
							rd = insn.r.rd;
						end
						FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
							rs = insn.r.rs; // Result goes to HI/LO
							rt = insn.r.rt;
						end
						FN_MFHI, FN_MFLO: begin
							rd = insn.r.rd;
						end
						FN_SLL, FN_SRL, FN_SRA: begin
							rt = insn.r.rt;
							rd = insn.r.rd;
							sa = insn.r.sa; // Immediate shift amount
						end
						FN_JR: begin
							rs = insn.r.rs;
						end
						default: begin
							r_known = 1'b0;
						end
					endcase

					if (r_known) begin
						opcode = OP_RTYPE;
						func   = insn.r.func;
						alu_op = insn.r.func;
					end else begin
						illegal = 1'b1;
					end
				end
			end

			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI,
			OP_LW, OP_SW, OP_LB, OP_LBU, OP_SB, OP_LUI,
			OP_BEQ, OP_BNE, OP_BGTZ: begin
				opcode = insn.i.opcode;
				rs     = (insn.i.opcode == OP_LUI) ? '0 : insn.i.rs; // LUI has no source
				rt     = insn.i.rt;
				alu_op = insn.i.opcode;
				imm_sx = {{(XLEN-IMM_W){insn.i.imm[IMM_W-1]}}, insn.i.imm};
			end

			OP_J, OP_JAL: begin
				opcode      = insn.j.opcode;
				alu_op      = insn.j.opcode;
				jump_target = insn.j.target;
			end

			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/decode_stage_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_regs import mips_decode_pkg::*; (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 enable_decode,
	input  logic [XLEN-1:0]      pc,
	input  logic [XLEN-1:0]      insn,
	input  logic [OPCODE_W-1:0]  opcode,
	input  logic [REG_IDX_W-1:0] rs,
	input  logic [REG_IDX_W-1:0] rt,
	input  logic [REG_IDX_W-1:0] rd,
	input  logic [SHAMT_W-1:0]   sa,
	input  logic [FUNC_W-1:0]    func,
	input  logic [OPCODE_W-1:0]  alu_op,
	input  logic [XLEN-1:0]      imm_sx,
	input  logic [TARGET_W-1:0]  jump_target,
	input  logic                 illegal,
	output logic [OPCODE_W-1:0]  opcode_out,
	output logic [REG_IDX_W-1:0] rs_out,
	output logic [REG_IDX_W-1:0] rt_out,
	output logic [REG_IDX_W-1:0] rd_out,
	output logic [SHAMT_W-1:0]   sa_out,
	output logic [FUNC_W-1:0]    func_out,
	output logic [OPCODE_W-1:0]  alu_op_out,
	output logic [XLEN-1:0]      imm_sx_out,
	output logic [TARGET_W-1:0]  jump_target_out,
	output logic                 illegal_out,
	output logic [XLEN-1:0]      pc_out,
	output logic [XLEN-1:0]      insn_out
);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			opcode_out      <= '0;
			rs_out          <= '0;
			rt_out          <= '0;
			rd_out          <= '0;
			sa_out          <= '0;
			func_out        <= '0;
			alu_op_out      <= '0;
			imm_sx_out      <= '0;
			jump_target_out <= '0;
			illegal_out     <= 1'b0;
			pc_out          <= '0;
			insn_out        <= '0;
		end else if (enable_decode) begin // Low enable stalls the stage
			opcode_out      <= opcode;
			rs_out          <= rs;
			rt_out          <= rt;
			rd_out          <= rd;
			sa_out          <= sa;
			func_out        <= func;
			alu_op_out      <= alu_op;
			imm_sx_out      <= imm_sx;
			jump_target_out <= jump_target;
			illegal_out     <= illegal;
			pc_out          <= pc;
			insn_out        <= insn;
		end
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_decode_pkg::*; (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic [REG_IDX_W-1:0] rs_addr,
	input  logic [REG_IDX_W-1:0] rt_addr,
	input  logic                 wb_we,
	input  logic [REG_IDX_W-1:0] wb_addr,
	input  logic [XLEN-1:0]      wb_data,
	output logic [XLEN-1:0]      rs_data,
	output logic [XLEN-1:0]      rt_data
);

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= XLEN'(i); // Register i comes up holding i
			end
		end else if (wb_we) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Asynchronous reads, old value until the write edge
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

/* hdl/mips_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decode_top import mips_decode_pkg::*; (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 enable_decode,
	input  insn_t                insn,
	input  logic [XLEN-1:0]      pc,
	input  logic                 wb_we,
	input  logic [REG_IDX_W-1:0] wb_addr,
	input  logic [XLEN-1:0]      wb_data,
	output logic [OPCODE_W-1:0]  opcode_out,
	output logic [REG_IDX_W-1:0] rs_out,
	output logic [REG_IDX_W-1:0] rt_out,
	output logic [REG_IDX_W-1:0] rd_out,
	output logic [SHAMT_W-1:0]   sa_out,
	output logic [FUNC_W-1:0]    func_out,
	output logic [OPCODE_W-1:0]  alu_op_out,
	output logic [XLEN-1:0]      imm_sx_out,
	output logic [TARGET_W-1:0]  jump_target_out,
	output logic                 illegal_out,
	output logic [XLEN-1:0]      pc_out,
	output logic [XLEN-1:0]      insn_out,
	output logic [XLEN-1:0]      rs_data,
	output logic [XLEN-1:0]      rt_data
);

	// Classifier results ahead of the stage register
	logic [OPCODE_W-1:0]  dec_opcode;
	logic [REG_IDX_W-1:0] dec_rs;
	logic [REG_IDX_W-1:0] dec_rt;
	logic [REG_IDX_W-1:0] dec_rd;
	logic [SHAMT_W-1:0]   dec_sa;
	logic [FUNC_W-1:0]    dec_func;
	logic [OPCODE_W-1:0]  dec_alu_op;
	logic [XLEN-1:0]      dec_imm_sx;
	logic [TARGET_W-1:0]  dec_jump_target;
	logic                 dec_illegal;

	insn_classifier u_classifier (
		.insn        (insn),
		.opcode      (dec_opcode),
		.rs          (dec_rs),
		.rt          (dec_rt),
		.rd          (dec_rd),
		.sa          (dec_sa),
		.func        (dec_func),
		.alu_op      (dec_alu_op),
		.imm_sx      (dec_imm_sx),
		.jump_target (dec_jump_target),
		.illegal     (dec_illegal)
	);

	decode_stage_regs u_stage_regs (
		.clock           (clock),
		.arst_n          (arst_n),
		.enable_decode   (enable_decode),
		.pc              (pc),
		.insn            (insn),
		.opcode          (dec_opcode),
		.rs              (dec_rs),
		.rt              (dec_rt),
		.rd              (dec_rd),
		.sa              (dec_sa),
		.func            (dec_func),
		.alu_op          (dec_alu_op),
		.imm_sx          (dec_imm_sx),
		.jump_target     (dec_jump_target),
		.illegal         (dec_illegal),
		.opcode_out      (opcode_out),
		.rs_out          (rs_out),
		.rt_out          (rt_out),
		.rd_out          (rd_out),
		.sa_out          (sa_out),
		.func_out        (func_out),
		.alu_op_out      (alu_op_out),
		.imm_sx_out      (imm_sx_out),
		.jump_target_out (jump_target_out),
		.illegal_out     (illegal_out),
		.pc_out          (pc_out),
		.insn_out        (insn_out)
	);

	// Operand reads follow the registered indexes
	reg_file u_reg_file (
		.clock   (clock),
		.arst_n  (arst_n),
		.rs_addr (rs_out),
		.rt_addr (rt_out),
		.wb_we   (wb_we),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

endmodule

`default_nettype wire

/* dv/decode_ref.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected decode of one word, straight from the field layout rules
task automatic ref_decode(
	input  logic [XLEN-1:0]      w,
	output logic [OPCODE_W-1:0]  e_opcode,
	output logic [REG_IDX_W-1:0] e_rs,
	output logic [REG_IDX_W-1:0] e_rt,
	output logic [REG_IDX_W-1:0] e_rd,
	output logic [SHAMT_W-1:0]   e_sa,
	output logic [FUNC_W-1:0]    e_func,
	output logic [OPCODE_W-1:0]  e_alu_op,
	output logic [XLEN-1:0]      e_imm_sx,
	output logic [TARGET_W-1:0]  e_jump_target,
	output logic                 e_illegal
);
	logic [OPCODE_W-1:0] op;
	logic [FUNC_W-1:0]   fn;
	logic [2:0]          uses; // rs, rt, rd in use
	logic                use_sa;
	logic                known;

	op            = w[31:26];
	fn            = w[5:0];
	e_opcode      = '0;
	e_rs          = '0;
	e_rt          = '0;
	e_rd          = '0;
	e_sa          = '0;
	e_func        = '0;
	e_alu_op      = '0;
	e_imm_sx      = '0;
	e_jump_target = '0;
	e_illegal     = 1'b0;
	uses          = 3'b000;
	use_sa        = 1'b0;
	known         = 1'b1;

	if (op == OP_RTYPE || op == OP_MUL) begin
		if (op == OP_MUL && fn == FN_MUL) begin
			uses = 3'b111;
		end else begin
			case (fn)
				FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: uses = 3'b110;
				FN_MFHI, FN_MFLO:                   uses = 3'b001;
				FN_JR:                              uses = 3'b100;
				FN_SLL, FN_SRL, FN_SRA: begin
					uses   = 3'b011;
					use_sa = 1'b1;
				end
				FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
				FN_SLLV, FN_SRLV, FN_SRAV, FN_AND, FN_OR, FN_XOR,
				FN_NOR, FN_JALR:                    uses = 3'b111;
				default:                            known = 1'b0;
			endcase
		end
		if (known) begin
			e_opcode = (op == OP_MUL && fn == FN_MUL) ? OP_MUL : OP_RTYPE;
			e_rs     = uses[2] ? w[25:21] : '0;
			e_rt     = uses[1] ? w[20:16] : '0;
			e_rd     = uses[0] ? w[15:11] : '0;
			e_sa     = use_sa ? w[10:6] : '0;
			e_func   = fn;
			e_alu_op = fn;
		end else begin
			e_illegal = 1'b1;
		end
	end else begin
		case (op)
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI, OP_LW, OP_SW,
			OP_LB, OP_LBU, OP_SB, OP_LUI, OP_BEQ, OP_BNE, OP_BGTZ: begin
				e_opcode = op;
				e_rs     = (op == OP_LUI) ? '0 : w[25:21];
				e_rt     = w[20:16];
				e_alu_op = op;
				e_imm_sx = {{16{w[15]}}, w[15:0]};
			end
			OP_J, OP_JAL: begin
				e_opcode      = op;
				e_alu_op      = op;
				e_jump_target = w[25:0];
			end
			default: e_illegal = 1'b1;
		endcase
	end
endtask

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic check_field(input string name, input logic [TARGET_W-1:0] exp,
		input logic [TARGET_W-1:0] act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
	end
endtask

task automatic check_word(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
	end
endtask

`endif

/* dv/decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_tb import mips_decode_pkg::*; ();

	localparam logic [31:0] LFSR_SEED = 32'd98652;
	localparam int LEN_RESET    = 24; // Upper bound of cycles per test
	localparam int LEN_RTYPE    = 28;
	localparam int LEN_IJ       = 36;
	localparam int LEN_ILLEGAL  = 20;
	localparam int LEN_WB       = 10;
	localparam int LEN_RANDOM   = 202;
	localparam int TIMEOUT_CYCLES =
		2 * (LEN_RESET + LEN_RTYPE + LEN_IJ + LEN_ILLEGAL + LEN_WB + LEN_RANDOM);

	logic                 clock;
	logic                 arst_n;
	logic                 enable_decode;
	logic [XLEN-1:0]      insn;
	logic [XLEN-1:0]      pc;
	logic                 wb_we;
	logic [REG_IDX_W-1:0] wb_addr;
	logic [XLEN-1:0]      wb_data;
	logic [OPCODE_W-1:0]  opcode_out;
	logic [REG_IDX_W-1:0] rs_out;
	logic [REG_IDX_W-1:0] rt_out;
	logic [REG_IDX_W-1:0] rd_out;
	logic [SHAMT_W-1:0]   sa_out;
	logic [FUNC_W-1:0]    func_out;
	logic [OPCODE_W-1:0]  alu_op_out;
	logic [XLEN-1:0]      imm_sx_out;
	logic [TARGET_W-1:0]  jump_target_out;
	logic                 illegal_out;
	logic [XLEN-1:0]      pc_out;
	logic [XLEN-1:0]      insn_out;
	logic [XLEN-1:0]      rs_data;
	logic [XLEN-1:0]      rt_data;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	logic [31:0] lfsr_state;
	logic [XLEN-1:0] shadow_regs [NUM_REGS]; // Expected register file contents
	logic [OPCODE_W-1:0] op_list [19];
	logic [FUNC_W-1:0]   fn_list [24];

	logic [OPCODE_W-1:0]  exp_opcode;
	logic [REG_IDX_W-1:0] exp_rs;
	logic [REG_IDX_W-1:0] exp_rt;
	logic [REG_IDX_W-1:0] exp_rd;
	logic [SHAMT_W-1:0]   exp_sa;
	logic [FUNC_W-1:0]    exp_func;
	logic [OPCODE_W-1:0]  exp_alu_op;
	logic [XLEN-1:0]      exp_imm_sx;
	logic [TARGET_W-1:0]  exp_jump_target;
	logic                 exp_illegal;
	logic [XLEN-1:0]      exp_pc;
	logic [XLEN-1:0]      exp_insn;

	`include "decode_ref.svh"

	mips_decode_top dut (
		.clock           (clock),
		.arst_n          (arst_n),
		.enable_decode   (enable_decode),
		.insn            (insn),
		.pc              (pc),
		.wb_we           (wb_we),
		.wb_addr         (wb_addr),
		.wb_data         (wb_data),
		.opcode_out      (opcode_out),
		.rs_out          (rs_out),
		.rt_out          (rt_out),
		.rd_out          (rd_out),
		.sa_out          (sa_out),
		.func_out        (func_out),
		.alu_op_out      (alu_op_out),
		.imm_sx_out      (imm_sx_out),
		.jump_target_out (jump_target_out),
		.illegal_out     (illegal_out),
		.pc_out          (pc_out),
		.insn_out        (insn_out),
		.rs_data         (rs_data),
		.rt_data         (rt_data)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v          = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic [XLEN-1:0] r_layout(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {op, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [XLEN-1:0] i_layout(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic compare_outputs();
		check_field("opcode_out", exp_opcode, opcode_out);
		check_field("rs_out", exp_rs, rs_out);
		check_field("rt_out", exp_rt, rt_out);
		check_field("rd_out", exp_rd, rd_out);
		check_field("sa_out", exp_sa, sa_out);
		check_field("func_out", exp_func, func_out);
		check_field("alu_op_out", exp_alu_op, alu_op_out);
		check_field("jump_target_out", exp_jump_target, jump_target_out);
		check_word("imm_sx_out", exp_imm_sx, imm_sx_out);
		check_word("pc_out", exp_pc, pc_out);
		check_word("insn_out", exp_insn, insn_out);
		check_word("rs_data", shadow_regs[exp_rs], rs_data);
		check_word("rt_data", shadow_regs[exp_rt], rt_data);
		check_flag("illegal_out", exp_illegal, illegal_out);
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic decode_and_compare(input logic [XLEN-1:0] w, input logic [XLEN-1:0] pc_val);
		insn          = w;
		pc            = pc_val;
		enable_decode = 1'b1;
		ref_decode(w, exp_opcode, exp_rs, exp_rt, exp_rd, exp_sa, exp_func, exp_alu_op,
			exp_imm_sx, exp_jump_target, exp_illegal);
		exp_pc   = pc_val;
		exp_insn = w;
		@(posedge clock);
		#1;
		enable_decode = 1'b0;
		compare_outputs();
	endtask

	task automatic reset_state_and_regs();
		{exp_opcode, exp_rs, exp_rt, exp_rd, exp_sa, exp_func, exp_alu_op} = '0;
		{exp_imm_sx, exp_jump_target, exp_illegal, exp_pc, exp_insn} = '0;
		compare_outputs();
		for (int k = 0; k < 16; k++) begin // Each pair of indexes reads its reset value
			decode_and_compare(r_layout(OP_RTYPE, 2 * k, 2 * k + 1, k, 0, FN_ADD), 32'h100 + 4 * k);
		end
	endtask

	task automatic rtype_decoding();
		for (int k = 0; k < 24; k++) begin
			decode_and_compare(r_layout(OP_RTYPE, k + 1, 31 - k, (7 * k + 3) % 32,
				(3 * k + 1) % 32, fn_list[k]), 32'h400 + 4 * k);
		end
		decode_and_compare(r_layout(OP_MUL, 5'd9, 5'd10, 5'd11, 5'd4, FN_MUL), 32'h0000_0480);
	endtask

	task automatic itype_jtype_decoding();
		for (int k = 2; k < 17; k++) begin
			decode_and_compare(i_layout(op_list[k], k, 31 - k, 16'h1234 + k), 32'h800 + 8 * k);
			decode_and_compare(i_layout(op_list[k], 31 - k, k, 16'h8000 | (16'h0f0f << (k % 4))),
				32'h804 + 8 * k);
		end
		decode_and_compare({OP_J, 26'h2ab_cdef}, 32'h0000_0900);
		decode_and_compare({OP_J, 26'h000_0001}, 32'h0000_0904);
		decode_and_compare({OP_JAL, 26'h3ff_ffff}, 32'h0000_0908);
		decode_and_compare({OP_JAL, 26'h155_5555}, 32'h0000_090c);
	endtask

	task automatic illegal_and_stall();
		logic [OPCODE_W-1:0] bad_ops [4];
		logic [FUNC_W-1:0]   bad_fns [4];
		bad_ops = '{6'h01, 6'h06, 6'h11, 6'h3f};
		bad_fns = '{6'h01, 6'h05, 6'h0c, 6'h3f};
		decode_and_compare(32'h0000_0000, 32'h0000_0000); // Decodes as all zeros
		for (int k = 0; k < 4; k++) begin
			decode_and_compare({bad_ops[k], 26'h3a5_5a5a}, 32'h0000_0a00 + 4 * k);
			decode_and_compare(r_layout(OP_RTYPE, 3, 4, 5, 6, bad_fns[k]), 32'h0000_0a10 + 4 * k);
		end
		decode_and_compare(i_layout(OP_ADDI, 5'd7, 5'd8, 16'hfff0), 32'h0000_0b00);
		for (int k = 0; k < 4; k++) begin // Stage must hold while enable is low
			insn = random_bits(32);
			pc   = random_bits(32);
			@(posedge clock);
			#1;
			compare_outputs();
		end
	endtask

	task automatic write_and_read(input logic [4:0] idx, input logic [XLEN-1:0] value);
		decode_and_compare(r_layout(OP_RTYPE, idx, idx, 5'd1, 5'd0, FN_ADD), 32'h0000_0c00);
		wb_we   = 1'b1;
		wb_addr = idx;
		wb_data = value;
		#1;
		check_word("rs_data", shadow_regs[idx], rs_data); // Old value before the write edge
		@(posedge clock);
		#1;
		wb_we            = 1'b0;
		shadow_regs[idx] = value;
		check_word("rs_data", value, rs_data);
		check_word("rt_data", value, rt_data);
	endtask

	task automatic writeback_readback();
		write_and_read(5'd13, 32'hdead_beef);
		write_and_read(5'd22, 32'h0123_4567);
	endtask

	task automatic random_words();
		logic [OPCODE_W-1:0] op;
		logic [TARGET_W-1:0] fields;
		logic [XLEN-1:0]     w;
		for (int n = 0; n < 200; n++) begin
			op     = op_list[random_bits(5) % 19];
			fields = random_bits(TARGET_W);
			w      = {op, fields};
			if (op == OP_RTYPE)
				w[5:0] = fn_list[random_bits(5) % 24];
			else if (op == OP_MUL)
				w[5:0] = FN_MUL;
			decode_and_compare(w, random_bits(32));
		end
	endtask

	initial begin
		clock         = 1'b0;
		arst_n        = 1'b0;
		enable_decode = 1'b0;
		insn          = '0;
		pc            = '0;
		wb_we         = 1'b0;
		wb_addr       = '0;
		wb_data       = '0;
		lfsr_state    = LFSR_SEED;
		for (int i = 0; i < NUM_REGS; i++)
			shadow_regs[i] = XLEN'(i);
		op_list = '{OP_RTYPE, OP_MUL, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI,
			OP_LW, OP_SW, OP_LB, OP_LBU, OP_SB, OP_LUI, OP_BEQ, OP_BNE, OP_BGTZ, OP_J, OP_JAL};
		fn_list = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
			FN_MFHI, FN_MFLO, FN_SLT, FN_SLTU, FN_SLL, FN_SLLV, FN_SRL, FN_SRLV,
			FN_SRA, FN_SRAV, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_JR, FN_JALR};
		repeat (5) @(posedge clock);
		#1;
		arst_n = 1'b1;

		reset_state_and_regs();
		rtype_decoding();
		itype_jtype_decoding();
		illegal_and_stall();
		writeback_readback();
		random_words();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+dv
hdl/mips_decode_pkg.sv
hdl/insn_classifier.sv
hdl/decode_stage_regs.sv
hdl/reg_file.sv
hdl/mips_decode_top.sv
dv/decode_tb.sv
